// ==== src/uart_cfg_pkg.sv ====
`default_nettype none

package uart_cfg_pkg;

   // Serial line timing
   localparam int CLKS_PER_BIT = 8;
   localparam int HALF_BIT     = CLKS_PER_BIT / 2;
   localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
   localparam int DATA_BITS    = 8;
   localparam int FRAME_BITS   = DATA_BITS + 2; // Start, data, stop

   // Transmit FIFO geometry
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = 4;

   typedef logic [DATA_BITS-1:0] byte_t;

   // Cycle counter within one bit time
   typedef logic [CLK_CNT_W-1:0] bit_tmr_t;

endpackage

`default_nettype wire

// ==== src/report_pkg.sv ====
`default_nettype none

package report_pkg;

   localparam int DP_WIDTH = 16;
   localparam int NUM_NIB  = DP_WIDTH / 4;  // Hex digits per word
   localparam int NIB_CW   = $clog2(NUM_NIB);

   // "R", digit, ":", hex digits, LF, CR
   localparam int MSG_LEN = NUM_NIB + 5;

   typedef logic [DP_WIDTH-1:0] dp_word_t;
   typedef logic [1:0]          reg_num_t;

   typedef struct packed {
      reg_num_t reg_num;
      dp_word_t data;
   } report_req_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_R,
      ST_REG,
      ST_COLON,
      ST_NIB,
      ST_NL,
      ST_CR
   } fmt_state_t;

endpackage

`default_nettype wire

// ==== src/report_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module report_formatter
   import uart_cfg_pkg::*, report_pkg::*;
(
   input  wire         clk,
   input  wire         rst,
   input  report_req_t i_req,
   input  wire         i_req_stb,
   input  wire         i_fifo_full,
   output byte_t       o_wr_data,
   output logic        o_wr_en,
   output logic        o_busy
);

   fmt_state_t              state;
   logic [NIB_CW-1:0]       nib_cnt;
   report_req_t             req_q;
   logic                    advance;

   function automatic byte_t nib2ascii(input logic [3:0] nib);
      if (nib < 4'd10)
         nib2ascii = 8'h30 + {4'h0, nib};       // '0'..'9'
      else
         nib2ascii = 8'h41 + {4'h0, nib} - 8'd10; // 'A'..'F'
   endfunction

   assign o_busy  = (state != ST_IDLE);
   assign advance = o_busy & ~i_fifo_full; // One character per free slot
   assign o_wr_en = advance;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= ST_IDLE;
         nib_cnt <= '0;
      end
      else if (state == ST_IDLE)
      begin
         if (i_req_stb)
            state <= ST_R;
      end
      else if (advance)
      begin
         unique case (state)
            ST_R:     state <= ST_REG;
            ST_REG:   state <= ST_COLON;
            ST_COLON:
            begin
               nib_cnt <= '0;
               state   <= ST_NIB;
            end
            ST_NIB:
            begin
               nib_cnt <= nib_cnt + 1'b1;
               if (nib_cnt == NIB_CW'(NUM_NIB - 1))
                  state <= ST_NL;
            end
            ST_NL:    state <= ST_CR;
            default:  state <= ST_IDLE; // CR written
         endcase
      end
   end

   // Request capture and nibble shifting
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && i_req_stb)
         req_q <= i_req;
      else if (state == ST_NIB && advance)
         req_q.data <= req_q.data << 4;
   end

   always_comb
   begin
      unique case (state)
         ST_R:     o_wr_data = "R";
         ST_REG:   o_wr_data = nib2ascii({2'b00, req_q.reg_num});
         ST_COLON: o_wr_data = ":";
         ST_NIB:   o_wr_data = nib2ascii(req_q.data[DP_WIDTH-1 -: 4]);
         ST_NL:    o_wr_data = 8'h0a;
         ST_CR:    o_wr_data = 8'h0d;
         default:  o_wr_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
   import uart_cfg_pkg::*;
(
   input  wire   clk,
   input  wire   rst,
   input  wire   i_wr,
   input  byte_t i_data,
   input  wire   i_rd,
   output byte_t o_data,
   output logic  o_full,
   output logic  o_empty
);

   byte_t              mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;
   logic               do_wr;
   logic               do_rd;

   assign o_full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign o_empty = (count == '0);
   assign do_wr   = i_wr & ~o_full;  // Dropped when full
   assign do_rd   = i_rd & ~o_empty;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   // Storage and registered read port
   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= i_data;
      if (do_rd)
         o_data <= mem[rd_ptr]; // Valid the cycle after the read
   end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import uart_cfg_pkg::*;
(
   input  wire   clk,
   input  wire   rst,
   input  wire   i_start,
   input  byte_t i_data,
   output logic  o_tx,
   output logic  o_active
);

   logic [FRAME_BITS-1:0]         shift_q;
   logic [$clog2(FRAME_BITS)-1:0] bit_idx;
   bit_tmr_t                      tmr;

   // Line idles high between frames
   assign o_tx = ~o_active | shift_q[0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         o_active <= 1'b0;
         tmr      <= '0;
         bit_idx  <= '0;
      end
      else if (!o_active)
      begin
         if (i_start)
         begin
            o_active <= 1'b1;
            tmr      <= '0;
            bit_idx  <= '0;
         end
      end
      else if (tmr == bit_tmr_t'(CLKS_PER_BIT - 1))
      begin
         tmr     <= '0;
         bit_idx <= bit_idx + 1'b1;
         if (bit_idx == ($clog2(FRAME_BITS))'(FRAME_BITS - 1))
            o_active <= 1'b0; // Stop bit done
      end
      else
         tmr <= tmr + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (!o_active && i_start)
         shift_q <= {1'b1, i_data, 1'b0}; // Stop, data LSB first, start
      else if (o_active && tmr == bit_tmr_t'(CLKS_PER_BIT - 1))
         shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
   end

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import uart_cfg_pkg::*;
(
   input  wire   clk,
   input  wire   rst,
   input  wire   i_rx,
   output byte_t o_data,
   output logic  o_valid
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                    state;
   logic                         rx_meta;
   logic                         rx_sync;
   bit_tmr_t                     tmr;
   logic [$clog2(DATA_BITS)-1:0] bit_idx;
   byte_t                        shift_q;
   logic                         bit_end;

   assign bit_end = (tmr == bit_tmr_t'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= RX_IDLE;
         tmr     <= '0;
         bit_idx <= '0;
         o_valid <= 1'b0;
      end
      else
      begin
         o_valid <= 1'b0;
         tmr     <= tmr + 1'b1;
         unique case (state)
            RX_IDLE:
            begin
               tmr <= '0;
               if (!rx_sync)
                  state <= RX_START; // Falling start edge
            end
            RX_START:
            begin
               if (rx_sync)
                  state <= RX_IDLE;  // Glitch, not a start bit
               else if (tmr == bit_tmr_t'(HALF_BIT - 1))
               begin
                  tmr     <= '0;     // Now centred on the start bit
                  bit_idx <= '0;
                  state   <= RX_DATA;
               end
            end
            RX_DATA:
               if (bit_end)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == ($clog2(DATA_BITS))'(DATA_BITS - 1))
                     state <= RX_STOP;
               end
            default:
               if (bit_end)
               begin
                  o_valid <= rx_sync; // Framing error gives no pulse
                  state   <= RX_IDLE;
               end
         endcase
      end
   end

   // Mid-bit sampling, LSB first
   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && bit_end)
         shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
      if (state == RX_STOP && bit_end && rx_sync)
         o_data <= shift_q;
   end

endmodule

`default_nettype wire

// ==== src/uart_report_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_report_top
   import uart_cfg_pkg::*, report_pkg::*;
(
   input  wire         clk,
   input  wire         rst,
   input  report_req_t i_report,
   input  wire         i_report_stb,
   output logic        o_busy,
   output logic        o_tx,
   input  wire         i_rx,
   output byte_t       o_rx_data,
   output logic        o_rx_valid
);

   byte_t fifo_wr_data;
   byte_t fifo_rd_data;
   logic  fifo_wr;
   logic  fifo_full;
   logic  fifo_empty;
   logic  fifo_rd;
   logic  fifo_rd_z;   // Doubles as the transmitter start
   logic  tx_active;

   report_formatter report_formatter_i (
      .clk         (clk),
      .rst         (rst),
      .i_req       (i_report),
      .i_req_stb   (i_report_stb),
      .i_fifo_full (fifo_full),
      .o_wr_data   (fifo_wr_data),
      .o_wr_en     (fifo_wr),
      .o_busy      (o_busy)
   );

   byte_fifo byte_fifo_i (
      .clk     (clk),
      .rst     (rst),
      .i_wr    (fifo_wr),
      .i_data  (fifo_wr_data),
      .i_rd    (fifo_rd),
      .o_data  (fifo_rd_data),
      .o_full  (fifo_full),
      .o_empty (fifo_empty)
   );

   // One read per idle transmitter; the extra cycle covers the start latency
   assign fifo_rd = ~fifo_empty & ~tx_active & ~fifo_rd_z;

   always_ff @(posedge clk)
   begin
      if (rst)
         fifo_rd_z <= 1'b0;
      else
         fifo_rd_z <= fifo_rd;
   end

   uart_tx uart_tx_i (
      .clk      (clk),
      .rst      (rst),
      .i_start  (fifo_rd_z),
      .i_data   (fifo_rd_data),
      .o_tx     (o_tx),
      .o_active (tx_active)
   );

   uart_rx uart_rx_i (
      .clk     (clk),
      .rst     (rst),
      .i_rx    (i_rx),
      .o_data  (o_rx_data),
      .o_valid (o_rx_valid)
   );

endmodule

`default_nettype wire

// ==== sim/uart_report_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_report_properties (
   input wire clk,
   input wire rst,
   input wire i_report_stb,
   input wire i_busy,
   input wire i_tx,
   input wire i_rx_valid
);

   // Delayed reset, so the first reset edge with unset flops is skipped
   logic rst_q = 1'b0;

   always_ff @(posedge clk)
   begin
      rst_q <= rst;
   end

   rx_valid_one_cycle: assert property (
      @(posedge clk) disable iff (rst) i_rx_valid |=> !i_rx_valid)
      else $error("o_rx_valid stayed high for two cycles");

   tx_high_in_reset: assert property (
      @(posedge clk) rst && rst_q |-> i_tx)
      else $error("o_tx not high during reset");

   busy_low_after_reset: assert property (
      @(posedge clk) rst |=> !i_busy)
      else $error("o_busy high right after a reset cycle");

   // A busy period can only start from an accepted strobe
   busy_needs_strobe: assert property (
      @(posedge clk) disable iff (rst) !i_busy && !i_report_stb |=> !i_busy)
      else $error("o_busy rose without a report strobe");

endmodule

`default_nettype wire

// ==== sim/tb_uart_report.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_report
   import uart_cfg_pkg::*, report_pkg::*;
();

   localparam int RESET_CYCLES   = 5;
   localparam int FRAME_CYCLES   = FRAME_BITS * CLKS_PER_BIT;
   localparam int TIMEOUT_CYCLES = 20000; // About 40 tx frames and 10 rx bytes, 4x margin
   localparam logic [8*16-1:0] HEX_TABLE = "0123456789ABCDEF";

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   report_req_t i_report;
   logic        i_report_stb;
   logic        i_rx;
   logic        o_busy;
   logic        o_tx;
   byte_t       o_rx_data;
   logic        o_rx_valid;

   byte_t  tx_expected [$];
   byte_t  rx_expected [$];
   int     tx_seen      = 0;
   int     rx_pulses    = 0;
   int     errors       = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   int     cycles       = 0;
   integer seed         = 32'hc8d1b4b8;

   uart_report_top uart_report_top_i (
      .clk          (clk),
      .rst          (rst),
      .i_report     (i_report),
      .i_report_stb (i_report_stb),
      .o_busy       (o_busy),
      .o_tx         (o_tx),
      .i_rx         (i_rx),
      .o_rx_data    (o_rx_data),
      .o_rx_valid   (o_rx_valid)
   );

   bind uart_report_top uart_report_properties uart_report_properties_i (
      .clk          (clk),
      .rst          (rst),
      .i_report_stb (i_report_stb),
      .i_busy       (o_busy),
      .i_tx         (o_tx),
      .i_rx_valid   (o_rx_valid)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic check_value(input logic ok, input string msg);
      assert (ok)
      else
      begin
         $display("mismatch at %0t: %s", $time, msg);
         errors++;
      end
   endtask

   function automatic byte_t hex_char(input int n);
      return HEX_TABLE[8*(15-n) +: 8];
   endfunction

   function automatic report_req_t random_report();
      logic [31:0] rnd;
      rnd = $random(seed);
      return report_req_t'(rnd[17:0]);
   endfunction

   // R, digit, colon, four hex digits MSB first, LF, CR
   task automatic expect_message(input report_req_t req);
      tx_expected.push_back("R");
      tx_expected.push_back(hex_char(int'(req.reg_num)));
      tx_expected.push_back(":");
      for (int i = NUM_NIB - 1; i >= 0; i--)
         tx_expected.push_back(hex_char(int'(req.data[4*i +: 4])));
      tx_expected.push_back(8'h0a);
      tx_expected.push_back(8'h0d);
   endtask

   task automatic send_report(input report_req_t req, input logic accepted);
      @(posedge clk);
      i_report     <= req;
      i_report_stb <= 1'b1;
      @(posedge clk);
      i_report_stb <= 1'b0;
      if (accepted)
         expect_message(req);
   endtask

   task automatic measure_busy(output int n);
      n = 0;
      @(negedge clk);
      while (o_busy)
      begin
         n++;
         @(negedge clk);
      end
   endtask

   task automatic wait_tx_drained(input int seen_before, input int chars);
      while (tx_expected.size() != 0)
         @(negedge clk);
      repeat (2 * FRAME_CYCLES) @(negedge clk); // Quiet window for stray characters
      check_value(tx_seen - seen_before == chars,
                  $sformatf("%0d characters on o_tx, expected %0d", tx_seen - seen_before, chars));
   endtask

   task automatic check_idle_outputs();
      check_value(o_tx === 1'b1 && o_busy === 1'b0 && o_rx_valid === 1'b0,
                  $sformatf("o_tx=%b o_busy=%b o_rx_valid=%b, expected 1 0 0",
                            o_tx, o_busy, o_rx_valid));
   endtask

   // Samples at negedge, start found half a cycle late, then mid-bit steps
   task automatic decode_tx_byte(output byte_t b, output logic framed);
      framed = 1'b1;
      b      = '0;
      @(negedge clk);
      while (o_tx !== 1'b0)
         @(negedge clk);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (o_tx !== 1'b0)
         framed = 1'b0;
      for (int i = 0; i < DATA_BITS; i++)
      begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         b[i] = o_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (o_tx !== 1'b1)
         framed = 1'b0;
   endtask

   task automatic hold_rx(input logic level, input int n);
      @(posedge clk);
      i_rx <= level;
      repeat (n - 1) @(posedge clk);
   endtask

   task automatic send_rx_byte(input byte_t b, input logic stop_level);
      if (stop_level)
         rx_expected.push_back(b);
      hold_rx(1'b0, CLKS_PER_BIT);
      for (int i = 0; i < DATA_BITS; i++)
         hold_rx(b[i], CLKS_PER_BIT);
      hold_rx(stop_level, CLKS_PER_BIT);
      hold_rx(1'b1, 2 * CLKS_PER_BIT); // Idle so the next start edge is clean
   endtask

   task automatic end_test(input string name, input int errors_before);
      tests_run++;
      if (errors != errors_before)
         tests_failed++;
      $display("test %0d %-16s %s", tests_run, name, (errors == errors_before) ? "ok" : "failed");
   endtask

   initial
   begin : tx_monitor
      byte_t ch;
      byte_t exp_ch;
      logic  framed;
      wait (rst == 1'b0);
      forever
      begin
         decode_tx_byte(ch, framed);
         tx_seen++;
         if (!framed)
         begin
            $display("error at %0t: bad start or stop bit on o_tx", $time);
            errors++;
         end
         if (tx_expected.size() == 0)
         begin
            $display("error at %0t: unexpected character 0x%02h on o_tx", $time, ch);
            errors++;
         end
         else
         begin
            exp_ch = tx_expected.pop_front();
            check_value(ch == exp_ch,
                        $sformatf("o_tx character 0x%02h, expected 0x%02h", ch, exp_ch));
         end
      end
   end

   always @(negedge clk)
   begin
      if (!rst && o_rx_valid)
      begin
         rx_pulses++;
         if (rx_expected.size() == 0)
         begin
            $display("error at %0t: o_rx_valid pulse with no byte sent", $time);
            errors++;
         end
         else
         begin
            check_value(o_rx_data == rx_expected[0],
                        $sformatf("o_rx_data 0x%02h, expected 0x%02h", o_rx_data, rx_expected[0]));
            rx_expected.delete(0);
         end
      end
   end

   initial
   begin : main
      report_req_t req;
      int          busy_cycles;
      int          errs_at_start;
      int          seen_at_start;
      int          pulses_at_start;
      logic [31:0] rnd;
      byte_t       b;
      byte_t       last_good;

      i_report     = '0;
      i_report_stb = 1'b0;
      i_rx         = 1'b1;

      // Reset values, during and after reset
      errs_at_start = errors;
      repeat (RESET_CYCLES - 1)
      begin
         @(negedge clk);
         check_idle_outputs();
      end
      @(posedge clk);
      rst <= 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         check_idle_outputs();
      end
      end_test("reset", errs_at_start);

      errs_at_start = errors;
      seen_at_start = tx_seen;
      req = random_report();
      send_report(req, 1'b1);
      measure_busy(busy_cycles);
      check_value(busy_cycles == MSG_LEN,
                  $sformatf("o_busy high %0d cycles, expected %0d", busy_cycles, MSG_LEN));
      wait_tx_drained(seen_at_start, MSG_LEN);
      end_test("single report", errs_at_start);

      // Second report fills the FIFO past its depth
      errs_at_start = errors;
      seen_at_start = tx_seen;
      send_report(random_report(), 1'b1);
      measure_busy(busy_cycles);
      send_report(random_report(), 1'b1);
      measure_busy(busy_cycles);
      check_value(busy_cycles > MSG_LEN,
                  $sformatf("second o_busy only %0d cycles under back-pressure", busy_cycles));
      wait_tx_drained(seen_at_start, 2 * MSG_LEN);
      end_test("back-to-back", errs_at_start);

      errs_at_start = errors;
      seen_at_start = tx_seen;
      send_report(random_report(), 1'b1);
      @(negedge clk);
      check_value(o_busy === 1'b1, "o_busy low right after an accepted strobe");
      send_report(random_report(), 1'b0); // Lands while busy
      wait_tx_drained(seen_at_start, MSG_LEN);
      end_test("strobe while busy", errs_at_start);

      errs_at_start = errors;
      last_good = '0;
      for (int i = 0; i < 8; i++)
      begin
         rnd = $random(seed);
         b = rnd[7:0];
         pulses_at_start = rx_pulses;
         send_rx_byte(b, 1'b1);
         check_value(rx_pulses == pulses_at_start + 1,
                     $sformatf("%0d o_rx_valid pulses for 0x%02h, expected 1",
                               rx_pulses - pulses_at_start, b));
         last_good = b;
      end
      end_test("receive", errs_at_start);

      errs_at_start = errors;
      rnd = $random(seed);
      pulses_at_start = rx_pulses;
      send_rx_byte(rnd[7:0], 1'b0);
      check_value(rx_pulses == pulses_at_start,
                  $sformatf("%0d o_rx_valid pulses for a low stop bit, expected 0",
                            rx_pulses - pulses_at_start));
      check_value(o_rx_data == last_good,
                  $sformatf("o_rx_data 0x%02h after framing error, expected 0x%02h",
                            o_rx_data, last_good));
      send_rx_byte(rnd[15:8], 1'b1);
      check_value(rx_pulses == pulses_at_start + 1,
                  $sformatf("%0d o_rx_valid pulses after recovery, expected 1",
                            rx_pulses - pulses_at_start));
      end_test("framing error", errs_at_start);

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
src/uart_cfg_pkg.sv
src/report_pkg.sv
src/report_formatter.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_report_top.sv
sim/uart_report_properties.sv
sim/tb_uart_report.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_uart_report
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= TESTS PASSED
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
